// File: source/pipe_pkg.sv
package pipe_pkg;

	localparam int data_w     = 32;
	localparam int reg_addr_w = 5;

	// Primary opcodes.
	localparam logic [5:0] op_special = 6'b000000;
	localparam logic [5:0] op_addiu   = 6'b001001;
	localparam logic [5:0] op_slti    = 6'b001010;
	localparam logic [5:0] op_andi    = 6'b001100;
	localparam logic [5:0] op_ori     = 6'b001101;
	localparam logic [5:0] op_xori    = 6'b001110;
	localparam logic [5:0] op_lui     = 6'b001111;

	// Function codes under op_special.
	localparam logic [5:0] fn_addu = 6'b100001;
	localparam logic [5:0] fn_subu = 6'b100011;
	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_xor  = 6'b100110;
	localparam logic [5:0] fn_nor  = 6'b100111;
	localparam logic [5:0] fn_slt  = 6'b101010;
	localparam logic [5:0] fn_sltu = 6'b101011;
	localparam logic [5:0] fn_sll  = 6'b000000;
	localparam logic [5:0] fn_srl  = 6'b000010;
	localparam logic [5:0] fn_sra  = 6'b000011;

	// ALU result groups; nop is all zero so a cleared register is a bubble.
	localparam logic [2:0] alusel_nop   = 3'b000;
	localparam logic [2:0] alusel_logic = 3'b001;
	localparam logic [2:0] alusel_shift = 3'b010;
	localparam logic [2:0] alusel_cmp   = 3'b011;
	localparam logic [2:0] alusel_arith = 3'b100;

	localparam logic [7:0] aluop_nop  = 8'b00000000;
	localparam logic [7:0] aluop_and  = 8'b00100100;
	localparam logic [7:0] aluop_or   = 8'b00100101;
	localparam logic [7:0] aluop_xor  = 8'b00100110;
	localparam logic [7:0] aluop_nor  = 8'b00100111;
	localparam logic [7:0] aluop_lui  = 8'b01011100;
	localparam logic [7:0] aluop_addu = 8'b00100001;
	localparam logic [7:0] aluop_subu = 8'b00100011;
	localparam logic [7:0] aluop_sll  = 8'b01111100;
	localparam logic [7:0] aluop_srl  = 8'b00000010;
	localparam logic [7:0] aluop_sra  = 8'b00000011;
	localparam logic [7:0] aluop_slt  = 8'b00101010;
	localparam logic [7:0] aluop_sltu = 8'b00101011;

	typedef struct packed {
		logic [5:0]            opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] rd;
		logic [4:0]            shamt;
		logic [5:0]            funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]            opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [15:0]           imm;
	} i_fmt_t;

	// One instruction word, two field layouts.
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} inst_word_u;

	typedef struct packed {
		logic [2:0]            alusel;
		logic [7:0]            aluop;
		logic [data_w-1:0]     reg1_data;
		logic [data_w-1:0]     reg2_data;
		logic                  we;
		logic [reg_addr_w-1:0] waddr;
	} ex_ctrl_t;

	typedef struct packed {
		logic                  we;
		logic [reg_addr_w-1:0] waddr;
		logic [data_w-1:0]     data;
	} wb_t;

endpackage

// File: source/inst_decode.sv
`timescale 1ns/100ps

module inst_decode import pipe_pkg::*; (
	input  inst_word_u            inst,
	input  logic                  inst_valid,
	input  logic [data_w-1:0]     rs_data,
	input  logic [data_w-1:0]     rt_data,
	output logic [reg_addr_w-1:0] rs_addr,
	output logic [reg_addr_w-1:0] rt_addr,
	input  wb_t                   ex_res,
	input  wb_t                   wb,
	output ex_ctrl_t              id_ctrl
);

	logic [data_w-1:0]     rs_val;
	logic [data_w-1:0]     rt_val;
	logic [data_w-1:0]     sext_imm;
	logic [data_w-1:0]     zext_imm;
	logic [data_w-1:0]     lui_imm;
	logic [data_w-1:0]     shamt_val;
	logic [2:0]            sel;
	logic [7:0]            op;
	logic [data_w-1:0]     op1;
	logic [data_w-1:0]     op2;
	logic [reg_addr_w-1:0] dst;
	logic                  ok;

	// rs and rt sit at the same bits in both formats.
	assign rs_addr = inst.r.rs;
	assign rt_addr = inst.r.rt;

	// Newest value wins: EX result, then WB, then the register file.
	assign rs_val = (ex_res.we && ex_res.waddr == rs_addr) ? ex_res.data :
			(wb.we && wb.waddr == rs_addr) ? wb.data : rs_data;
	assign rt_val = (ex_res.we && ex_res.waddr == rt_addr) ? ex_res.data :
			(wb.we && wb.waddr == rt_addr) ? wb.data : rt_data;

	assign sext_imm  = {{16{inst.i.imm[15]}}, inst.i.imm};
	assign zext_imm  = {16'b0, inst.i.imm};
	assign lui_imm   = {inst.i.imm, 16'b0};
	assign shamt_val = {{(data_w-5){1'b0}}, inst.r.shamt}; // Shift amount as operand 1.

	always_comb begin
		sel = alusel_nop;
		op  = aluop_nop;
		op1 = rs_val;
		op2 = rt_val;
		dst = inst.r.rd;
		ok  = 1'b1;
		if (inst.r.opcode == op_special) begin
			case (inst.r.funct)
				fn_addu: begin sel = alusel_arith; op = aluop_addu; end
				fn_subu: begin sel = alusel_arith; op = aluop_subu; end
				fn_and:  begin sel = alusel_logic; op = aluop_and;  end
				fn_or:   begin sel = alusel_logic; op = aluop_or;   end
				fn_xor:  begin sel = alusel_logic; op = aluop_xor;  end
				fn_nor:  begin sel = alusel_logic; op = aluop_nor;  end
				fn_slt:  begin sel = alusel_cmp;   op = aluop_slt;  end
				fn_sltu: begin sel = alusel_cmp;   op = aluop_sltu; end
				fn_sll: begin
					sel = alusel_shift;
					op  = aluop_sll;
					op1 = shamt_val;
				end
				fn_srl: begin
					sel = alusel_shift;
					op  = aluop_srl;
					op1 = shamt_val;
				end
				fn_sra: begin
					sel = alusel_shift;
					op  = aluop_sra;
					op1 = shamt_val;
				end
				default: ok = 1'b0; // Unknown funct.
			endcase
		end else begin
			dst = inst.i.rt; // I-type writes rt.
			case (inst.i.opcode)
				op_addiu: begin sel = alusel_arith; op = aluop_addu; op2 = sext_imm; end
				op_slti:  begin sel = alusel_cmp;   op = aluop_slt;  op2 = sext_imm; end
				op_andi:  begin sel = alusel_logic; op = aluop_and;  op2 = zext_imm; end
				op_ori:   begin sel = alusel_logic; op = aluop_or;   op2 = zext_imm; end
				op_xori:  begin sel = alusel_logic; op = aluop_xor;  op2 = zext_imm; end
				op_lui: begin
					sel = alusel_logic;
					op  = aluop_lui;
					op1 = '0;
					op2 = lui_imm;
				end
				default: ok = 1'b0;
			endcase
		end
	end

	// Invalid slots and unsupported encodings leave as bubbles.
	always_comb begin
		if (inst_valid && ok) begin
			id_ctrl.alusel    = sel;
			id_ctrl.aluop     = op;
			id_ctrl.reg1_data = op1;
			id_ctrl.reg2_data = op2;
			id_ctrl.we        = (dst != '0); // Register 0 is never written.
			id_ctrl.waddr     = dst;
		end else begin
			id_ctrl.alusel    = alusel_nop;
			id_ctrl.aluop     = aluop_nop;
			id_ctrl.reg1_data = '0;
			id_ctrl.reg2_data = '0;
			id_ctrl.we        = 1'b0;
			id_ctrl.waddr     = '0;
		end
	end

endmodule

// File: source/reg_file.sv
`timescale 1ns/100ps

module reg_file import pipe_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic [reg_addr_w-1:0] rs_addr,
	input  logic [reg_addr_w-1:0] rt_addr,
	output logic [data_w-1:0]     rs_data,
	output logic [data_w-1:0]     rt_data,
	input  wb_t                   wb
);

	localparam int num_regs = 1 << reg_addr_w;

	logic [data_w-1:0] regs [0:num_regs-1];

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we && wb.waddr != '0) begin
			regs[wb.waddr] <= wb.data; // Single write port.
		end
	end

	// Same-cycle writes reach decode through the forwarding path.
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: source/id_ex.sv
`timescale 1ns/100ps

module id_ex import pipe_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  logic     stall,
	input  logic     flush,
	input  ex_ctrl_t id_ctrl,
	output ex_ctrl_t ex_ctrl
);

	// Flush beats stall; a cleared entry is a nop bubble.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ex_ctrl.alusel    <= alusel_nop;
			ex_ctrl.aluop     <= aluop_nop;
			ex_ctrl.reg1_data <= '0;
			ex_ctrl.reg2_data <= '0;
			ex_ctrl.we        <= 1'b0;
			ex_ctrl.waddr     <= '0;
		end else if (flush) begin
			ex_ctrl.alusel    <= alusel_nop;
			ex_ctrl.aluop     <= aluop_nop;
			ex_ctrl.reg1_data <= '0;
			ex_ctrl.reg2_data <= '0;
			ex_ctrl.we        <= 1'b0;
			ex_ctrl.waddr     <= '0;
		end else if (!stall) begin
			ex_ctrl.alusel    <= id_ctrl.alusel;
			ex_ctrl.aluop     <= id_ctrl.aluop;
			ex_ctrl.reg1_data <= id_ctrl.reg1_data;
			ex_ctrl.reg2_data <= id_ctrl.reg2_data;
			ex_ctrl.we        <= id_ctrl.we;
			ex_ctrl.waddr     <= id_ctrl.waddr;
		end
	end

endmodule

// File: source/alu_ex.sv
`timescale 1ns/100ps

module alu_ex import pipe_pkg::*; (
	input  ex_ctrl_t ex_ctrl,
	output wb_t      ex_res
);

	logic [data_w-1:0] op1;
	logic [data_w-1:0] op2;
	logic [4:0]        sh;
	logic [data_w-1:0] logic_res;
	logic [data_w-1:0] arith_res;
	logic [data_w-1:0] shift_res;
	logic [data_w-1:0] cmp_res;
	logic [data_w-1:0] result;

	assign op1 = ex_ctrl.reg1_data;
	assign op2 = ex_ctrl.reg2_data;
	assign sh  = op1[4:0]; // Only the low 5 bits count.

	always_comb begin
		case (ex_ctrl.aluop)
			aluop_and: logic_res = op1 & op2;
			aluop_or:  logic_res = op1 | op2;
			aluop_xor: logic_res = op1 ^ op2;
			aluop_nor: logic_res = ~(op1 | op2);
			aluop_lui: logic_res = op2; // Immediate already shifted.
			default:   logic_res = '0;
		endcase
	end

	always_comb begin
		case (ex_ctrl.aluop)
			aluop_addu: arith_res = op1 + op2;
			aluop_subu: arith_res = op1 - op2;
			default:    arith_res = '0;
		endcase
	end

	always_comb begin
		case (ex_ctrl.aluop)
			aluop_sll: shift_res = op2 << sh;
			aluop_srl: shift_res = op2 >> sh;
			aluop_sra: shift_res = $signed(op2) >>> sh;
			default:   shift_res = '0;
		endcase
	end

	always_comb begin
		case (ex_ctrl.aluop)
			aluop_slt:  cmp_res = {{(data_w-1){1'b0}}, $signed(op1) < $signed(op2)};
			aluop_sltu: cmp_res = {{(data_w-1){1'b0}}, op1 < op2};
			default:    cmp_res = '0;
		endcase
	end

	// Group select.
	always_comb begin
		case (ex_ctrl.alusel)
			alusel_logic: result = logic_res;
			alusel_arith: result = arith_res;
			alusel_shift: result = shift_res;
			alusel_cmp:   result = cmp_res;
			default:      result = '0;
		endcase
	end

	assign ex_res.we    = ex_ctrl.we && (ex_ctrl.alusel != alusel_nop);
	assign ex_res.waddr = ex_ctrl.waddr;
	assign ex_res.data  = result;

endmodule

// File: source/ex_wb.sv
`timescale 1ns/100ps

module ex_wb import pipe_pkg::*; (
	input  logic clk,
	input  logic reset_n,
	input  logic stall,
	input  wb_t  ex_res,
	output wb_t  wb
);

	// A held EX entry retires only on the edge that releases the stall.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wb.we    <= 1'b0;
			wb.waddr <= '0;
			wb.data  <= '0;
		end else if (stall) begin
			wb.we    <= 1'b0; // Bubble.
			wb.waddr <= '0;
			wb.data  <= '0;
		end else begin
			wb <= ex_res;
		end
	end

endmodule

// File: source/exec_core.sv
`timescale 1ns/100ps

module exec_core import pipe_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       inst_valid,
	input  inst_word_u inst,
	input  logic       stall,
	input  logic       flush,
	output wb_t        wb
);

	logic [reg_addr_w-1:0] rs_addr;
	logic [reg_addr_w-1:0] rt_addr;
	logic [data_w-1:0]     rs_data;
	logic [data_w-1:0]     rt_data;
	ex_ctrl_t              id_ctrl;
	ex_ctrl_t              ex_ctrl;
	wb_t                   ex_res;
	logic                  wb_hold;

	// Flush overrides stall, so the EX entry still retires.
	assign wb_hold = stall & ~flush;

	inst_decode u_inst_decode (
		.inst       (inst),
		.inst_valid (inst_valid),
		.rs_data    (rs_data),
		.rt_data    (rt_data),
		.rs_addr    (rs_addr),
		.rt_addr    (rt_addr),
		.ex_res     (ex_res),
		.wb         (wb),
		.id_ctrl    (id_ctrl)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.reset_n (reset_n),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wb      (wb)
	);

	id_ex u_id_ex (
		.clk     (clk),
		.reset_n (reset_n),
		.stall   (stall),
		.flush   (flush),
		.id_ctrl (id_ctrl),
		.ex_ctrl (ex_ctrl)
	);

	alu_ex u_alu_ex (
		.ex_ctrl (ex_ctrl),
		.ex_res  (ex_res)
	);

	ex_wb u_ex_wb (
		.clk     (clk),
		.reset_n (reset_n),
		.stall   (wb_hold),
		.ex_res  (ex_res),
		.wb      (wb)
	);

endmodule

// File: testbench/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [data_w-1:0] arch_regs [0:31]; // Architectural register state.
wb_t               exp_q [$];        // Expected writes, oldest first.

function automatic void model_reset();
	for (int i = 0; i < 32; i++) begin
		arch_regs[i] = '0;
	end
	exp_q.delete();
endfunction

// Instruction semantics; returns 0 for an encoding outside the supported set.
function automatic bit model_result(input inst_word_u w, output logic [reg_addr_w-1:0] dst,
		output logic [data_w-1:0] value);
	logic [data_w-1:0] a;
	logic [data_w-1:0] b;
	logic [data_w-1:0] sx;
	logic [data_w-1:0] zx;
	a     = arch_regs[w.r.rs];
	b     = arch_regs[w.r.rt];
	sx    = {{16{w.i.imm[15]}}, w.i.imm};
	zx    = {16'h0000, w.i.imm};
	dst   = w.r.rd;
	value = '0;
	model_result = 1'b1;
	if (w.r.opcode == op_special) begin
		case (w.r.funct)
			fn_addu: value = a + b;
			fn_subu: value = a - b;
			fn_and:  value = a & b;
			fn_or:   value = a | b;
			fn_xor:  value = a ^ b;
			fn_nor:  value = ~(a | b);
			fn_slt:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			fn_sltu: value = (a < b) ? 32'd1 : 32'd0;
			fn_sll:  value = b << w.r.shamt;
			fn_srl:  value = b >> w.r.shamt;
			fn_sra:  value = $signed(b) >>> w.r.shamt;
			default: model_result = 1'b0;
		endcase
	end else begin
		dst = w.i.rt;
		case (w.i.opcode)
			op_addiu: value = a + sx;
			op_slti:  value = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
			op_andi:  value = a & zx;
			op_ori:   value = a | zx;
			op_xori:  value = a ^ zx;
			op_lui:   value = {w.i.imm, 16'h0000};
			default:  model_result = 1'b0;
		endcase
	end
endfunction

// Retires one accepted instruction in program order.
function automatic void model_retire(input inst_word_u w);
	logic [reg_addr_w-1:0] dst;
	logic [data_w-1:0]     value;
	wb_t                   exp;
	if (model_result(w, dst, value) && dst != '0) begin
		arch_regs[dst] = value;
		exp.we    = 1'b1;
		exp.waddr = dst;
		exp.data  = value;
		exp_q.push_back(exp);
	end
endfunction

`endif

// File: testbench/tb_exec_core.sv
`timescale 1ns/100ps

module tb_exec_core import pipe_pkg::*; ();

	localparam int num_cycles    = 2000;
	localparam int reset_cycles  = 5;
	localparam int timeout_limit = num_cycles + reset_cycles + 50;

	logic        clk = 1'b0;
	logic        reset_n;
	logic        inst_valid;
	inst_word_u  inst;
	logic        stall;
	logic        flush;
	wb_t         wb;
	bit          need_new;
	bit          consumed;
	int unsigned cycle_count = 0;

	`include "ref_model.svh"

	exec_core UUT (
		.clk        (clk),
		.reset_n    (reset_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.stall      (stall),
		.flush      (flush),
		.wb         (wb)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	task automatic halt_on_error(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			halt_on_error($sformatf("FAIL %s expected 0x%08h actual 0x%08h",
				name, expected, actual));
		end
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_limit) begin
			halt_on_error($sformatf("Timeout: the run did not end within %0d cycles",
				timeout_limit));
		end
	end

	function automatic bit is_supported_opcode(input logic [5:0] op);
		case (op)
			op_special, op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Registers 0 to 7 only so that dependencies come often.
	function automatic inst_word_u random_inst();
		inst_word_u  w;
		int unsigned pick;
		w      = inst_word_u'($urandom());
		w.r.rs = 5'($urandom_range(0, 7));
		w.r.rt = 5'($urandom_range(0, 7));
		if ($urandom_range(0, 99) < 3) begin
			while (is_supported_opcode(w.r.opcode)) begin
				w.r.opcode = 6'($urandom());
			end
			return w;
		end
		pick = $urandom_range(0, 16);
		if (pick < 11) begin
			w.r.opcode = op_special;
			w.r.rd     = 5'($urandom_range(0, 7));
			w.r.shamt  = (pick >= 8) ? 5'($urandom()) : 5'd0; // Shifts only.
			case (pick)
				0:       w.r.funct = fn_addu;
				1:       w.r.funct = fn_subu;
				2:       w.r.funct = fn_and;
				3:       w.r.funct = fn_or;
				4:       w.r.funct = fn_xor;
				5:       w.r.funct = fn_nor;
				6:       w.r.funct = fn_slt;
				7:       w.r.funct = fn_sltu;
				8:       w.r.funct = fn_sll;
				9:       w.r.funct = fn_srl;
				default: w.r.funct = fn_sra;
			endcase
		end else begin
			case (pick)
				11:      w.i.opcode = op_addiu;
				12:      w.i.opcode = op_slti;
				13:      w.i.opcode = op_andi;
				14:      w.i.opcode = op_ori;
				15:      w.i.opcode = op_xori;
				default: w.i.opcode = op_lui;
			endcase
		end
		return w;
	endfunction

	task automatic check_wb();
		wb_t exp;
		if (wb.we) begin
			if (exp_q.size() == 0) begin
				halt_on_error($sformatf("Unexpected write of 0x%08h to register %0d",
					wb.data, wb.waddr));
			end else begin
				exp = exp_q.pop_front();
				check_value("writeback_waddr", exp.waddr, wb.waddr);
				check_value("writeback_data", exp.data, wb.data);
			end
		end
	endtask

	// Model the acceptance edge, then check WB on the falling edge.
	task automatic advance(output bit taken);
		@(posedge clk);
		taken = 1'b0;
		if (reset_n && inst_valid && !stall && !flush) begin
			model_retire(inst);
			taken = 1'b1;
		end else if (reset_n && inst_valid && flush) begin
			taken = 1'b1; // Flushed and never modeled.
		end
		@(negedge clk);
		check_wb();
	endtask

	initial begin
		void'($urandom(96));
		reset_n    = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		stall      = 1'b0;
		flush      = 1'b0;
		need_new   = 1'b1;
		model_reset();

		repeat (reset_cycles) begin
			@(negedge clk);
			check_value("reset_wb_we", 0, wb.we);
		end
		reset_n = 1'b1;
		advance(consumed);
		check_value("first_cycle_wb_we", 0, wb.we);

		// Isolated ADDIU r3, r0, 0x8001.
		inst       = '0;
		inst.i.opcode = op_addiu;
		inst.i.rt  = 5'd3;
		inst.i.imm = 16'h8001;
		inst_valid = 1'b1;
		advance(consumed); // Edge N.
		check_value("latency_ex_wb_we", 0, wb.we);
		inst_valid = 1'b0;
		advance(consumed); // Edge N+1.
		check_value("latency_wb_we", 1, wb.we);
		check_value("latency_wb_data", 32'hffff8001, wb.data);
		check_value("latency_pending", 0, exp_q.size());

		for (int c = 0; c < num_cycles; c++) begin
			if (need_new) begin
				inst = random_inst();
			end
			inst_valid = ($urandom_range(0, 99) < 85);
			stall      = ($urandom_range(0, 99) < 20);
			flush      = ($urandom_range(0, 99) < 5);
			advance(consumed);
			need_new = consumed;
		end

		inst_valid = 1'b0;
		stall      = 1'b0;
		flush      = 1'b0;
		repeat (3) begin
			advance(consumed);
		end

		if (exp_q.size() != 0) begin
			halt_on_error($sformatf("Missing writes: %0d expected results never reached WB",
				exp_q.size()));
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// File: files.f
+incdir+testbench
source/pipe_pkg.sv
source/inst_decode.sv
source/reg_file.sv
source/id_ex.sv
source/alu_ex.sv
source/ex_wb.sv
source/exec_core.sv
testbench/tb_exec_core.sv
